// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - files:
      - source/cpu_types_pkg.sv
      - source/isa_pkg.sv
      - source/ex_uimm_bank.sv
      - source/ex_alu.sv
      - source/ex_branch_unit.sv
      - source/ex_pipe_reg.sv
      - source/ex_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/ex_stage_tb.sv

// ==== include/ex_vectors.svh ====
`ifndef EX_VECTORS_SVH
`define EX_VECTORS_SVH

// Each row gives opc, cc, bank_sel, imm12, src_val, tgt_val, flags_in, stall and flush
// followed by the expected result, flags (V N C Z), flags_we, branch_taken and branch_pc
task automatic load_vectors();
    // Register ALU
    add_row(OPC_MOVur, CC_RA, 0, 'h0, 'h0, 'h5, 'h0, 0, 0, 'h0, 'h1, 1, 0, 'h0);
    add_row(OPC_ADDur, CC_RA, 0, 'h0, 'hFFFFFF, 'h1, 'h0, 0, 0, 'h0, 'h3, 1, 0, 'h0);
    add_row(OPC_SUBur, CC_RA, 0, 'h0, 'h5, 'h3, 'h0, 0, 0, 'hFFFFFE, 'h2, 1, 0, 'h0);
    add_row(OPC_ANDur, CC_RA, 0, 'h0, 'hF0F0F0, 'h0F0F0F, 'h0, 0, 0, 'h0, 'h1, 1, 0, 'h0);
    add_row(OPC_NOTur, CC_RA, 0, 'h0, 'h0, 'hFFFFFF, 'h0, 0, 0, 'h0, 'h1, 1, 0, 'h0);
    add_row(OPC_ADDsr, CC_RA, 0, 'h0, 'h7FFFFF, 'h1, 'h0, 0, 0, 'h800000, 'hC, 1, 0, 'h0);
    add_row(OPC_ADDsr, CC_RA, 0, 'h0, 'hFFFFFF, 'h1, 'h0, 0, 0, 'h0, 'h1, 1, 0, 'h0);
    add_row(OPC_SUBsr, CC_RA, 0, 'h0, 'h1, 'h800000, 'h0, 0, 0, 'h7FFFFF, 'h8, 1, 0, 'h0);
    add_row(OPC_SHLur, CC_RA, 0, 'h0, 'h5, 'h080001, 'h0, 0, 0, 'h20, 'h2, 1, 0, 'h0);
    add_row(OPC_SHRur, CC_RA, 0, 'h0, 'h5, 'h31, 'h0, 0, 0, 'h1, 'h2, 1, 0, 'h0);
    add_row(OPC_SHLur, CC_RA, 0, 'h0, 'h1E, 'hFFFFFF, 'h0, 0, 0, 'h0, 'h1, 1, 0, 'h0);
    add_row(OPC_SHLur, CC_RA, 0, 'h0, 'h20, 'h123456, 'h0, 0, 0, 'h123456, 'h0, 1, 0, 'h0);
    add_row(OPC_SHRur, CC_RA, 0, 'h0, 'h0, 'hABCDEF, 'h0, 0, 0, 'hABCDEF, 'h0, 0, 0, 'h0);
    add_row(OPC_CMPur, CC_RA, 0, 'h0, 'h3, 'h7, 'h0, 0, 0, 'h0, 'h2, 1, 0, 'h0);
    add_row(OPC_TSTur, CC_RA, 0, 'h0, 'h9, 'h0, 'h0, 0, 0, 'h0, 'h1, 1, 0, 'h0);
    // Banks, far jump, stall and flush
    add_row(OPC_LUIui, CC_RA, 0, 'hABC, 'h0, 'h0, 'h0, 0, 0, 'h0, 'h0, 0, 0, 'h0);
    add_row(OPC_LUIui, CC_RA, 1, 'hDEF, 'h0, 'h0, 'h0, 0, 0, 'h0, 'h0, 0, 0, 'h0);
    add_row(OPC_LUIui, CC_RA, 2, 'h123, 'h0, 'h0, 'h0, 0, 0, 'h0, 'h0, 0, 0, 'h0);
    add_row(OPC_MOVui, CC_RA, 0, 'h456, 'h0, 'h0, 'h0, 0, 0, 'hABC456, 'h0, 1, 0, 'h0);
    add_row(OPC_ADDui, CC_RA, 0, 'hFFF, 'h0, 'h543001, 'h0, 0, 0, 'h0, 'h3, 1, 0, 'h0);
    add_row(OPC_JCCui, CC_RA, 0, 'h789, 'h0, 'h0, 'h0, 0, 0, 'h0, 'h0, 0, 1, 'h123DEFABC789);
    add_row(OPC_LUIui, CC_RA, 0, 'hFFF, 'h0, 'h0, 'h0, 1, 0, 'h0, 'h0, 0, 0, 'h0);
    add_row(OPC_MOVui, CC_RA, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 'hABC000, 'h0, 1, 0, 'h0);
    add_row(OPC_MOVur, CC_RA, 0, 'h0, 'h111111, 'h0, 'h0, 0, 1, 'h0, 'h0, 0, 0, 'h0);
    add_row(OPC_MOVui, CC_RA, 0, 'h456, 'h0, 'h0, 'h0, 0, 0, 'h456, 'h0, 1, 0, 'h0);
    // Conditions on a register jump
    add_row(OPC_JCCur, CC_EQ, 0, 'h0, 'h0, 'h0, 'h1, 0, 0, 'h0, 'h0, 0, 1, 'h123456789ABC);
    add_row(OPC_JCCur, CC_NE, 0, 'h0, 'h0, 'h0, 'h1, 0, 0, 'h0, 'h0, 0, 0, 'h123456789ABC);
    add_row(OPC_JCCur, CC_LT, 0, 'h0, 'h0, 'h0, 'h4, 0, 0, 'h0, 'h0, 0, 1, 'h123456789ABC);
    add_row(OPC_JCCur, CC_GE, 0, 'h0, 'h0, 'h0, 'h4, 0, 0, 'h0, 'h0, 0, 0, 'h123456789ABC);
    add_row(OPC_JCCur, CC_GT, 0, 'h0, 'h0, 'h0, 'hC, 0, 0, 'h0, 'h0, 0, 1, 'h123456789ABC);
    add_row(OPC_JCCur, CC_LE, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 'h0, 'h0, 0, 0, 'h123456789ABC);
    add_row(OPC_JCCur, CC_BT, 0, 'h0, 'h0, 'h0, 'h2, 0, 0, 'h0, 'h0, 0, 1, 'h123456789ABC);
    add_row(OPC_JCCur, CC_AE, 0, 'h0, 'h0, 'h0, 'h2, 0, 0, 'h0, 'h0, 0, 0, 'h123456789ABC);
    add_row(OPC_JCCur, CC_AT, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 'h0, 'h0, 0, 1, 'h123456789ABC);
    add_row(OPC_JCCur, CC_BE, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 'h0, 'h0, 0, 0, 'h123456789ABC);
    // Negative offset from pc 0x100000
    add_row(OPC_BCCso, CC_RA, 0, 'hFF0, 'h0, 'h0, 'h0, 0, 0, 'h0, 'h0, 0, 1, 'hFFFF0);
    add_row(OPC_MCCur, CC_EQ, 0, 'h0, 'hAA, 'hBB, 'h1, 0, 0, 'hAA, 'h0, 1, 0, 'h0);
    add_row(OPC_MCCur, CC_EQ, 0, 'h0, 'hAA, 'hBB, 'h0, 0, 0, 'hBB, 'h0, 0, 0, 'h0);
endtask

`endif

// ==== bench/ex_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb
    import cpu_types_pkg::*;
    import isa_pkg::*;
();
    localparam addr_t PC_VAL = 48'h0000_0010_0000;
    localparam addr_t AR_VAL = 48'h1234_5678_9ABC;
    localparam int    N_RAND = 6;

    typedef struct packed {
        opc_t      opc;
        cc_t       cc;
        bank_sel_t bank_sel;
        imm12_t    imm12;
        data_t     src;
        data_t     tgt;
        flags_t    fin;
        logic      stall;
        logic      flush;
        data_t     res;
        flags_t    flg;
        logic      fwe;
        logic      bt;
        addr_t     bpc;
    } vec_t;

    typedef struct packed {
        data_t   res;
        flags_t  flg;
        logic    fwe;
        gp_idx_t gp;
        logic    gpwe;
        logic    bt;
        addr_t   bpc;
    } out_t;

    logic      iw_clk;
    logic      iw_rst;
    addr_t     pc;
    opc_t      opc;
    cc_t       cc;
    imm12_t    imm12;
    bank_sel_t bank_sel;
    gp_idx_t   wb_gp_in;
    logic      wb_gp_we_in;
    data_t     src_val;
    data_t     tgt_val;
    addr_t     tgt_ar_val;
    flags_t    flags_in;
    logic      stall;
    logic      flush;
    data_t     result;
    flags_t    flags;
    logic      flags_we;
    gp_idx_t   wb_gp;
    logic      wb_gp_we;
    logic      branch_taken;
    addr_t     branch_pc;

    vec_t   vectors[$];
    out_t   exp_out = '0;
    integer seed;
    int     cycles = 0;
    int     cycle_limit = 0;
    int     passed = 0;
    int     failed = 0;
    int     mismatches;

    ex_stage dut (.*);

    always #20 iw_clk = ~iw_clk;

    // Watchdog on the clock
    always @(posedge iw_clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic add_row(input opc_t o, input cc_t c, input bank_sel_t bs, input imm12_t imm,
                           input data_t s, input data_t t, input flags_t fi, input logic st,
                           input logic fl, input data_t r, input flags_t f, input logic we,
                           input logic b, input addr_t bp);
        vec_t v;
        v = '{o, c, bs, imm, s, t, fi, st, fl, r, f, we, b, bp};
        vectors.push_back(v);
    endtask

    `include "ex_vectors.svh"

    // Carry of the random adds comes from a 25-bit sum
    task automatic add_random_rows();
        data_t  a;
        data_t  b;
        data_t  r;
        flags_t f;
        opc_t   o;
        logic   carry;
        int     k;
        for (k = 0; k < N_RAND; k++) begin
            a = data_t'($random(seed));
            b = data_t'($random(seed));
            f = '0;
            carry = 1'b0;
            case (k % 3)
                0: begin
                    o = OPC_ADDur;
                    {carry, r} = {1'b0, a} + {1'b0, b};
                end
                1: begin
                    o = OPC_SUBur;
                    r = b - a;
                    carry = (b < a);
                end
                default: begin
                    o = OPC_XORur;
                    r = a ^ b;
                end
            endcase
            f[FLAG_Z] = (r == '0);
            f[FLAG_C] = carry;
            add_row(o, CC_RA, 0, 'h0, a, b, 'h0, 0, 0, r, f, 1, 0, 'h0);
        end
    endtask

    task automatic apply_row(input int i);
        vec_t v;
        v = vectors[i];
        opc         <= v.opc;
        cc          <= v.cc;
        bank_sel    <= v.bank_sel;
        imm12       <= v.imm12;
        src_val     <= v.src;
        tgt_val     <= v.tgt;
        flags_in    <= v.fin;
        stall       <= v.stall;
        flush       <= v.flush;
        wb_gp_in    <= gp_idx_t'(i);
        wb_gp_we_in <= i[0];
    endtask

    task automatic report_mismatch(input string tag, input string sig,
                                   input logic [63:0] exp, input logic [63:0] got);
        $display("ERR %s %s expected %h got %h", tag, sig, exp, got);
        mismatches++;
    endtask

    task automatic check_outputs(input string tag);
        mismatches = 0;
        if (result !== exp_out.res)
            report_mismatch(tag, "result", 64'(exp_out.res), 64'(result));
        if (flags !== exp_out.flg)
            report_mismatch(tag, "flags", 64'(exp_out.flg), 64'(flags));
        if (flags_we !== exp_out.fwe)
            report_mismatch(tag, "flags_we", 64'(exp_out.fwe), 64'(flags_we));
        if (wb_gp !== exp_out.gp)
            report_mismatch(tag, "wb_gp", 64'(exp_out.gp), 64'(wb_gp));
        if (wb_gp_we !== exp_out.gpwe)
            report_mismatch(tag, "wb_gp_we", 64'(exp_out.gpwe), 64'(wb_gp_we));
        if (branch_taken !== exp_out.bt)
            report_mismatch(tag, "branch_taken", 64'(exp_out.bt), 64'(branch_taken));
        if (branch_pc !== exp_out.bpc)
            report_mismatch(tag, "branch_pc", 64'(exp_out.bpc), 64'(branch_pc));
        if (mismatches == 0) begin
            passed++;
            $display("%s ok", tag);
        end else begin
            failed++;
            $display("%s failed with %0d mismatches", tag, mismatches);
        end
    endtask

    // A stalled row keeps the last outputs
    task automatic check_row(input int i);
        vec_t v;
        v = vectors[i];
        if (v.flush)
            exp_out = '0;
        else if (!v.stall)
            exp_out = '{v.res, v.flg, v.fwe, gp_idx_t'(i), i[0], v.bt, v.bpc};
        check_outputs($sformatf("row %0d opc %h", i, v.opc));
    endtask

    initial begin
        int i;
        seed        = 10;
        iw_clk      = 1'b0;
        iw_rst      = 1'b1;
        pc          = PC_VAL;
        opc         = OPC_NOP;
        cc          = CC_RA;
        imm12       = '0;
        bank_sel    = '0;
        wb_gp_in    = '0;
        wb_gp_we_in = 1'b0;
        src_val     = '0;
        tgt_val     = '0;
        tgt_ar_val  = AR_VAL;
        flags_in    = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        load_vectors();
        add_random_rows();
        cycle_limit = 2 * vectors.size() + 20;

        repeat (3) @(posedge iw_clk);
        iw_rst <= 1'b0;
        @(negedge iw_clk);
        check_outputs("reset");

        // Row i goes in while row i-1 comes out
        for (i = 0; i <= vectors.size(); i++) begin
            @(posedge iw_clk);
            if (i < vectors.size()) begin
                apply_row(i);
            end else begin
                opc   <= OPC_NOP;
                stall <= 1'b0;
                flush <= 1'b0;
            end
            @(negedge iw_clk);
            if (i > 0)
                check_row(i - 1);
        end

        $display("Tests run %0d, passed %0d, failed %0d", passed + failed, passed, failed);
        if (failed == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
source/cpu_types_pkg.sv
source/isa_pkg.sv
source/ex_uimm_bank.sv
source/ex_alu.sv
source/ex_branch_unit.sv
source/ex_pipe_reg.sv
source/ex_stage.sv
bench/ex_stage_tb.sv

// ==== source/cpu_types_pkg.sv ====
`default_nettype none

package cpu_types_pkg;

    localparam int DATA_W  = 24;
    localparam int ADDR_W  = 48;
    localparam int IMM12_W = 12;

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [IMM12_W-1:0] imm12_t;
    typedef logic [3:0]         flags_t;
    typedef logic [3:0]         gp_idx_t;
    typedef logic [1:0]         bank_sel_t;

    // Data side of the stage output
    typedef struct packed {
        data_t   result;
        flags_t  flags;
        logic    flags_we;
        gp_idx_t wb_gp;
        logic    wb_gp_we;
    } alu_out_t;

    // Branch side of the stage output
    typedef struct packed {
        logic  branch_taken;
        addr_t branch_pc;
    } br_out_t;

endpackage

`default_nettype wire

// ==== source/ex_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_alu
    import cpu_types_pkg::*;
    import isa_pkg::*;
(
    input  opc_t     opc,
    input  data_t    src_val,
    input  data_t    tgt_val,
    input  data_t    uimm,
    input  logic     cond_true,
    input  gp_idx_t  wb_gp_in,
    input  logic     wb_gp_we_in,
    output alu_out_t alu
);
    data_t           res;
    flags_t          fl;
    logic            fl_we;
    logic [4:0]      shamt;
    logic            src_nz;
    logic            overshift;
    logic [DATA_W:0] shl_ext;
    logic [DATA_W:0] shr_ext;

    assign shamt     = src_val[4:0];
    assign src_nz    = (src_val != '0);
    assign overshift = (shamt >= DATA_W);
    // One extra bit keeps the last bit shifted out
    assign shl_ext   = {1'b0, tgt_val} << shamt;
    assign shr_ext   = {tgt_val, 1'b0} >> shamt;

    always_comb begin
        res   = '0;
        fl    = '0;
        fl_we = 1'b0;
        case (opc)
            OPC_MOVur, OPC_ANDur, OPC_ORur, OPC_XORur, OPC_NOTur, OPC_MOVui: begin
                case (opc)
                    OPC_MOVur: res = src_val;
                    OPC_ANDur: res = src_val & tgt_val;
                    OPC_ORur:  res = src_val | tgt_val;
                    OPC_XORur: res = src_val ^ tgt_val;
                    OPC_NOTur: res = ~tgt_val;
                    default:   res = uimm;
                endcase
                fl[FLAG_Z] = (res == '0);
                fl_we      = 1'b1;
            end
            OPC_ADDur: begin
                res        = src_val + tgt_val;
                fl[FLAG_Z] = (res == '0);
                fl[FLAG_C] = (res < src_val);
                fl_we      = 1'b1;
            end
            OPC_ADDui: begin
                res        = tgt_val + uimm;
                fl[FLAG_Z] = (res == '0);
                fl[FLAG_C] = (res < tgt_val);
                fl_we      = 1'b1;
            end
            OPC_SUBur: begin
                res        = tgt_val - src_val;
                fl[FLAG_Z] = (res == '0);
                fl[FLAG_C] = (tgt_val < src_val);
                fl_we      = 1'b1;
            end
            OPC_ADDsr: begin
                res        = src_val + tgt_val;
                fl[FLAG_Z] = (res == '0);
                fl[FLAG_N] = res[DATA_W-1];
                // Same-sign operands with a result of the other sign
                fl[FLAG_V] = ~(src_val[DATA_W-1] ^ tgt_val[DATA_W-1]) &
                             (src_val[DATA_W-1] ^ res[DATA_W-1]);
                fl_we      = 1'b1;
            end
            OPC_SUBsr: begin
                res        = tgt_val - src_val;
                fl[FLAG_Z] = (res == '0);
                fl[FLAG_N] = res[DATA_W-1];
                fl[FLAG_V] = (src_val[DATA_W-1] ^ tgt_val[DATA_W-1]) &
                             (tgt_val[DATA_W-1] ^ res[DATA_W-1]);
                fl_we      = 1'b1;
            end
            OPC_SHLur: begin
                res = overshift ? '0 : shl_ext[DATA_W-1:0];
                if (src_nz) begin
                    fl[FLAG_C] = overshift ? 1'b0 : shl_ext[DATA_W];
                    fl[FLAG_Z] = (res == '0);
                    fl_we      = 1'b1;
                end
            end
            OPC_SHRur: begin
                res = overshift ? '0 : shr_ext[DATA_W:1];
                if (src_nz) begin
                    fl[FLAG_C] = overshift ? 1'b0 : shr_ext[0];
                    fl[FLAG_Z] = (res == '0);
                    fl_we      = 1'b1;
                end
            end
            OPC_CMPur: begin
                fl[FLAG_Z] = (src_val == tgt_val);
                fl[FLAG_C] = (src_val < tgt_val);
                fl_we      = 1'b1;
            end
            OPC_TSTur: begin
                fl[FLAG_Z] = (tgt_val == '0);
                fl_we      = 1'b1;
            end
            OPC_MCCur: begin
                if (cond_true) begin
                    res        = src_val;
                    fl[FLAG_Z] = (res == '0);
                    fl_we      = 1'b1;
                end else begin
                    // Not taken writes back the old value
                    res = tgt_val;
                end
            end
            // Bank writes and branches leave the data path idle
            default: begin
                res = '0;
            end
        endcase
    end

    assign alu = '{
        result:   res,
        flags:    fl,
        flags_we: fl_we,
        wb_gp:    wb_gp_in,
        wb_gp_we: wb_gp_we_in
    };

endmodule

`default_nettype wire

// ==== source/ex_branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit
    import cpu_types_pkg::*;
    import isa_pkg::*;
(
    input  opc_t    opc,
    input  cc_t     cc,
    input  flags_t  flags_in,
    input  addr_t   pc,
    input  imm12_t  imm12,
    input  addr_t   tgt_ar_val,
    input  addr_t   far_target,
    output logic    cond_true,
    output br_out_t br
);
    logic  z;
    logic  c;
    logic  n;
    logic  v;
    addr_t rel_target;

    assign z = flags_in[FLAG_Z];
    assign c = flags_in[FLAG_C];
    assign n = flags_in[FLAG_N];
    assign v = flags_in[FLAG_V];

    assign rel_target = pc + {{(ADDR_W-IMM12_W){imm12[IMM12_W-1]}}, imm12};

    always_comb begin
        case (cc)
            CC_RA:   cond_true = 1'b1;
            CC_EQ:   cond_true = z;
            CC_NE:   cond_true = ~z;
            CC_LT:   cond_true = n ^ v;
            CC_GE:   cond_true = ~(n ^ v);
            CC_GT:   cond_true = ~z & ~(n ^ v);
            CC_LE:   cond_true = z | (n ^ v);
            CC_BT:   cond_true = c;
            CC_AE:   cond_true = ~c;
            CC_AT:   cond_true = ~c & ~z;
            CC_BE:   cond_true = c | z;
            default: cond_true = 1'b0;
        endcase
    end

    // Branch opcodes always present their target
    always_comb begin
        br = '0;
        case (opc)
            OPC_JCCui: begin
                br.branch_taken = cond_true;
                br.branch_pc    = far_target;
            end
            OPC_JCCur: begin
                br.branch_taken = cond_true;
                br.branch_pc    = tgt_ar_val;
            end
            OPC_BCCso: begin
                br.branch_taken = cond_true;
                br.branch_pc    = rel_target;
            end
            default: begin
                br = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/ex_pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     iw_clk,
    input  logic     iw_rst,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Flush wins over stall
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== source/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage
    import cpu_types_pkg::*;
    import isa_pkg::*;
(
    input  logic      iw_clk,
    input  logic      iw_rst,
    input  addr_t     pc,
    input  opc_t      opc,
    input  cc_t       cc,
    input  imm12_t    imm12,
    input  bank_sel_t bank_sel,
    input  gp_idx_t   wb_gp_in,
    input  logic      wb_gp_we_in,
    input  data_t     src_val,
    input  data_t     tgt_val,
    input  addr_t     tgt_ar_val,
    input  flags_t    flags_in,
    input  logic      stall,
    input  logic      flush,
    output data_t     result,
    output flags_t    flags,
    output logic      flags_we,
    output gp_idx_t   wb_gp,
    output logic      wb_gp_we,
    output logic      branch_taken,
    output addr_t     branch_pc
);
    data_t    uimm;
    addr_t    far_target;
    logic     cond_true;
    alu_out_t alu_d;
    alu_out_t alu_q;
    br_out_t  br_d;
    br_out_t  br_q;

    ex_uimm_bank u_uimm_bank (
        .iw_clk     (iw_clk),
        .iw_rst     (iw_rst),
        .stall      (stall),
        .flush      (flush),
        .opc        (opc),
        .bank_sel   (bank_sel),
        .imm12      (imm12),
        .uimm       (uimm),
        .far_target (far_target)
    );

    ex_branch_unit u_branch_unit (
        .opc        (opc),
        .cc         (cc),
        .flags_in   (flags_in),
        .pc         (pc),
        .imm12      (imm12),
        .tgt_ar_val (tgt_ar_val),
        .far_target (far_target),
        .cond_true  (cond_true),
        .br         (br_d)
    );

    ex_alu u_alu (
        .opc         (opc),
        .src_val     (src_val),
        .tgt_val     (tgt_val),
        .uimm        (uimm),
        .cond_true   (cond_true),
        .wb_gp_in    (wb_gp_in),
        .wb_gp_we_in (wb_gp_we_in),
        .alu         (alu_d)
    );

    ex_pipe_reg #(.payload_t(alu_out_t)) u_alu_reg (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .stall  (stall),
        .flush  (flush),
        .d      (alu_d),
        .q      (alu_q)
    );

    ex_pipe_reg #(.payload_t(br_out_t)) u_br_reg (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .stall  (stall),
        .flush  (flush),
        .d      (br_d),
        .q      (br_q)
    );

    assign result       = alu_q.result;
    assign flags        = alu_q.flags;
    assign flags_we     = alu_q.flags_we;
    assign wb_gp        = alu_q.wb_gp;
    assign wb_gp_we     = alu_q.wb_gp_we;
    assign branch_taken = br_q.branch_taken;
    assign branch_pc    = br_q.branch_pc;

endmodule

`default_nettype wire

// ==== source/ex_uimm_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_uimm_bank
    import cpu_types_pkg::*;
    import isa_pkg::*;
(
    input  logic      iw_clk,
    input  logic      iw_rst,
    input  logic      stall,
    input  logic      flush,
    input  opc_t      opc,
    input  bank_sel_t bank_sel,
    input  imm12_t    imm12,
    output data_t     uimm,
    output addr_t     far_target
);
    imm12_t bank0;
    imm12_t bank1;
    imm12_t bank2;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            bank0 <= '0;
            bank1 <= '0;
            bank2 <= '0;
        end else if (flush) begin
            bank0 <= '0;
            bank1 <= '0;
            bank2 <= '0;
        end else if (!stall && opc == OPC_LUIui) begin
            case (bank_sel)
                2'd1:    bank1 <= imm12;
                2'd2:    bank2 <= imm12;
                // Select 3 falls back to bank 0
                default: bank0 <= imm12;
            endcase
        end
    end

    assign uimm       = {bank0, imm12};
    assign far_target = {bank2, bank1, bank0, imm12};

endmodule

`default_nettype wire

// ==== source/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef logic [5:0] opc_t;
    typedef logic [3:0] cc_t;

    // Opcode zero is a bubble
    localparam opc_t OPC_NOP   = 6'h00;
    localparam opc_t OPC_MOVur = 6'h01;
    localparam opc_t OPC_ADDur = 6'h02;
    localparam opc_t OPC_SUBur = 6'h03;
    localparam opc_t OPC_ANDur = 6'h04;
    localparam opc_t OPC_ORur  = 6'h05;
    localparam opc_t OPC_XORur = 6'h06;
    localparam opc_t OPC_NOTur = 6'h07;
    localparam opc_t OPC_SHLur = 6'h08;
    localparam opc_t OPC_SHRur = 6'h09;
    localparam opc_t OPC_CMPur = 6'h0A;
    localparam opc_t OPC_TSTur = 6'h0B;
    localparam opc_t OPC_ADDsr = 6'h10;
    localparam opc_t OPC_SUBsr = 6'h11;
    localparam opc_t OPC_LUIui = 6'h18;
    localparam opc_t OPC_MOVui = 6'h19;
    localparam opc_t OPC_ADDui = 6'h1A;
    localparam opc_t OPC_MCCur = 6'h20;
    localparam opc_t OPC_JCCui = 6'h28;
    localparam opc_t OPC_JCCur = 6'h29;
    localparam opc_t OPC_BCCso = 6'h2A;

    // Condition codes
    localparam cc_t CC_RA = 4'h0;
    localparam cc_t CC_EQ = 4'h1;
    localparam cc_t CC_NE = 4'h2;
    localparam cc_t CC_LT = 4'h3;
    localparam cc_t CC_GT = 4'h4;
    localparam cc_t CC_GE = 4'h5;
    localparam cc_t CC_LE = 4'h6;
    localparam cc_t CC_BT = 4'h7;
    localparam cc_t CC_AT = 4'h8;
    localparam cc_t CC_BE = 4'h9;
    localparam cc_t CC_AE = 4'hA;

    // Bit positions in the flag word
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_N = 2;
    localparam int FLAG_V = 3;

endpackage

`default_nettype wire
